/* hdl/dtlb_cfg.svh */
`ifndef DTLB_CFG_SVH
`define DTLB_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Translation buffer sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Entries held by each array. Both arrays always hold the same pages.
`define DTLB_ENTRIES 4

`define VADDR_WIDTH 32
`define PADDR_WIDTH 32

// 4 KiB pages.
`define PAGE_OFFSET_WIDTH 12

// Page numbers are what is left above the offset.
`define VPN_WIDTH (`VADDR_WIDTH - `PAGE_OFFSET_WIDTH)
`define PPN_WIDTH (`PADDR_WIDTH - `PAGE_OFFSET_WIDTH)

`endif

/* hdl/dtlb_pkg.sv */
`include "dtlb_cfg.svh"
`default_nettype none

package dtlb_pkg;

    // Which port owns an access or an outstanding walk.
    typedef enum logic {
        SRC_LOAD  = 1'b0,
        SRC_STORE = 1'b1
    } tlb_source_e;

    // Miss arbiter states. Only one page walk is ever in flight.
    typedef enum logic {
        ARB_IDLE = 1'b0,
        ARB_WALK = 1'b1
    } arb_state_e;

    typedef struct packed {
        logic readable;
        logic writable;
    } tlb_perm_t;

    // One translation, as stored in both arrays.
    typedef struct packed {
        logic [`VPN_WIDTH-1:0] vpn;
        logic [`PPN_WIDTH-1:0] ppn;
        tlb_perm_t             perm;
    } tlb_entry_t;

endpackage

`default_nettype wire

/* hdl/tlb_refill_if.sv */
`timescale 1ns/1ps
`include "dtlb_cfg.svh"
`default_nettype none

// Refill path from the miss arbiter to both translation arrays.
interface tlb_refill_if;
    import dtlb_pkg::*;

    logic                             we;
    logic [$clog2(`DTLB_ENTRIES)-1:0] widx;
    tlb_entry_t                       entry;
    logic                             inval_all;

    modport arbiter (
        output we,
        output widx,
        output entry,
        output inval_all
    );

    // Both arrays listen to the same instance.
    modport array (
        input we,
        input widx,
        input entry,
        input inval_all
    );

endinterface

`default_nettype wire

/* hdl/dtlb_array.sv */
`timescale 1ns/1ps
`include "dtlb_cfg.svh"
`default_nettype none

module dtlb_array #(
    parameter dtlb_pkg::tlb_source_e ACCESS = dtlb_pkg::SRC_LOAD
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    req,
    input  logic [`VADDR_WIDTH-1:0] vaddr,
    output logic                    hit,
    output logic                    miss,
    output logic                    exception,
    output logic [`PADDR_WIDTH-1:0] paddr,
    output logic [`VPN_WIDTH-1:0]   miss_vpn,
    tlb_refill_if.array             refill
);
    import dtlb_pkg::*;

    tlb_entry_t                    entries [`DTLB_ENTRIES];
    logic [`DTLB_ENTRIES-1:0]      valid;

    logic [`VPN_WIDTH-1:0]         req_vpn;
    logic [`PAGE_OFFSET_WIDTH-1:0] req_offset;
    logic [`DTLB_ENTRIES-1:0]      match;
    logic                          any_match;
    tlb_entry_t                    match_entry;
    logic                          perm_ok;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // A flush in the same cycle as a refill leaves the slot invalid.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
        end else if (refill.inval_all) begin
            valid <= '0;
        end else if (refill.we) begin
            valid[refill.widx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (refill.we) begin
            entries[refill.widx] <= refill.entry;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Lookup
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign req_vpn    = vaddr[`VADDR_WIDTH-1:`PAGE_OFFSET_WIDTH];
    assign req_offset = vaddr[`PAGE_OFFSET_WIDTH-1:0];

    // Fully associative compare. The lowest matching slot is taken,
    // although a page is only ever filled once between flushes.
    always_comb begin
        match_entry = '0;
        for (int i = 0; i < `DTLB_ENTRIES; i++) begin
            match[i] = valid[i] && (entries[i].vpn == req_vpn);
        end
        for (int i = `DTLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                match_entry = entries[i];
            end
        end
    end

    assign any_match = |match;

    // Loads need read permission, stores need write permission.
    assign perm_ok = (ACCESS == SRC_LOAD) ? match_entry.perm.readable
                                          : match_entry.perm.writable;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hit       <= 1'b0;
            miss      <= 1'b0;
            exception <= 1'b0;
        end else begin
            hit       <= req && any_match && perm_ok;
            exception <= req && any_match && !perm_ok;
            miss      <= req && !any_match;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            paddr    <= {match_entry.ppn, req_offset};
            miss_vpn <= req_vpn;
        end
    end

endmodule

`default_nettype wire

/* hdl/dtlb_miss_arbiter.sv */
`timescale 1ns/1ps
`include "dtlb_cfg.svh"
`default_nettype none

module dtlb_miss_arbiter (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    flush,
    input  logic                    ld_miss,
    input  logic                    st_miss,
    input  logic [`VPN_WIDTH-1:0]   ld_miss_vpn,
    input  logic [`VPN_WIDTH-1:0]   st_miss_vpn,
    output logic                    ld_cancel,
    output logic                    st_cancel,
    output logic                    ld_wb,
    output logic                    st_wb,
    output logic                    wb_error,
    output logic                    l2_req,
    output dtlb_pkg::tlb_source_e   l2_source,
    output logic [`VADDR_WIDTH-1:0] l2_vaddr,
    input  logic                    l2_valid,
    input  logic                    l2_error,
    input  logic [`PPN_WIDTH-1:0]   l2_ppn,
    input  dtlb_pkg::tlb_perm_t     l2_perm,
    tlb_refill_if.arbiter           refill
);
    import dtlb_pkg::*;

    localparam int IDX_W = $clog2(`DTLB_ENTRIES);

    arb_state_e            state;
    tlb_source_e           walk_owner;
    logic [`VPN_WIDTH-1:0] walk_vpn;
    logic [IDX_W-1:0]      victim;

    logic                  walk_start;
    logic                  walk_done;
    tlb_source_e           start_owner;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Walk control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Stores win when both ports miss together.
    assign start_owner = st_miss ? SRC_STORE : SRC_LOAD;
    assign walk_start  = (state == ARB_IDLE) && (ld_miss || st_miss) && !flush;

    // A response in idle belongs to an abandoned walk and is dropped.
    assign walk_done = (state == ARB_WALK) && l2_valid && !flush;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ARB_IDLE;
        end else if (flush) begin
            state <= ARB_IDLE;
        end else begin
            case (state)
                ARB_IDLE: if (walk_start) state <= ARB_WALK;
                ARB_WALK: if (walk_done)  state <= ARB_IDLE;
                default:  state <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            walk_owner <= SRC_LOAD;
        end else if (walk_start) begin
            walk_owner <= start_owner;
        end
    end

    always_ff @(posedge clk) begin
        if (walk_start) begin
            walk_vpn <= st_miss ? st_miss_vpn : ld_miss_vpn;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Port pulses
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Every miss that did not start the walk has to replay.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            l2_req    <= 1'b0;
            ld_cancel <= 1'b0;
            st_cancel <= 1'b0;
            ld_wb     <= 1'b0;
            st_wb     <= 1'b0;
            wb_error  <= 1'b0;
        end else begin
            l2_req    <= walk_start;
            ld_cancel <= ld_miss && !(walk_start && start_owner == SRC_LOAD);
            st_cancel <= st_miss && !(walk_start && start_owner == SRC_STORE);
            ld_wb     <= walk_done && (walk_owner == SRC_LOAD);
            st_wb     <= walk_done && (walk_owner == SRC_STORE);
            wb_error  <= walk_done && l2_error;
        end
    end

    assign l2_source = walk_owner;
    assign l2_vaddr  = {walk_vpn, {`PAGE_OFFSET_WIDTH{1'b0}}};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Refill and victim choice
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Round robin over the slots, stepping only on a real write.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            victim <= '0;
        end else if (refill.we) begin
            if (victim == IDX_W'(`DTLB_ENTRIES - 1)) begin
                victim <= '0;
            end else begin
                victim <= victim + 1'b1;
            end
        end
    end

    assign refill.we        = walk_done && !l2_error;
    assign refill.widx      = victim;
    assign refill.entry     = tlb_entry_t'{vpn: walk_vpn, ppn: l2_ppn, perm: l2_perm};
    assign refill.inval_all = flush;

endmodule

`default_nettype wire

/* hdl/dtlb_top.sv */
`timescale 1ns/1ps
`include "dtlb_cfg.svh"
`default_nettype none

module dtlb_top (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    flush,

    input  logic                    ld_req,
    input  logic [`VADDR_WIDTH-1:0] ld_vaddr,
    output logic                    ld_hit,
    output logic                    ld_miss,
    output logic                    ld_exception,
    output logic [`PADDR_WIDTH-1:0] ld_paddr,
    output logic                    ld_cancel,
    output logic                    ld_wb,

    input  logic                    st_req,
    input  logic [`VADDR_WIDTH-1:0] st_vaddr,
    output logic                    st_hit,
    output logic                    st_miss,
    output logic                    st_exception,
    output logic [`PADDR_WIDTH-1:0] st_paddr,
    output logic                    st_cancel,
    output logic                    st_wb,

    output logic                    wb_error,

    output logic                    l2_req,
    output dtlb_pkg::tlb_source_e   l2_source,
    output logic [`VADDR_WIDTH-1:0] l2_vaddr,
    input  logic                    l2_valid,
    input  logic [`PPN_WIDTH-1:0]   l2_ppn,
    input  dtlb_pkg::tlb_perm_t     l2_perm,
    input  logic                    l2_error
);
    import dtlb_pkg::*;

    logic [`VPN_WIDTH-1:0] ld_miss_vpn;
    logic [`VPN_WIDTH-1:0] st_miss_vpn;

    // Shared by the arbiter and both arrays.
    tlb_refill_if refill ();

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Translation arrays
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    dtlb_array #(
        .ACCESS (SRC_LOAD)
    ) i_ld_array (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (ld_req),
        .vaddr     (ld_vaddr),
        .hit       (ld_hit),
        .miss      (ld_miss),
        .exception (ld_exception),
        .paddr     (ld_paddr),
        .miss_vpn  (ld_miss_vpn),
        .refill    (refill.array)
    );

    dtlb_array #(
        .ACCESS (SRC_STORE)
    ) i_st_array (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (st_req),
        .vaddr     (st_vaddr),
        .hit       (st_hit),
        .miss      (st_miss),
        .exception (st_exception),
        .paddr     (st_paddr),
        .miss_vpn  (st_miss_vpn),
        .refill    (refill.array)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Miss handling
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    dtlb_miss_arbiter i_arbiter (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (flush),
        .ld_miss     (ld_miss),
        .st_miss     (st_miss),
        .ld_miss_vpn (ld_miss_vpn),
        .st_miss_vpn (st_miss_vpn),
        .ld_cancel   (ld_cancel),
        .st_cancel   (st_cancel),
        .ld_wb       (ld_wb),
        .st_wb       (st_wb),
        .wb_error    (wb_error),
        .l2_req      (l2_req),
        .l2_source   (l2_source),
        .l2_vaddr    (l2_vaddr),
        .l2_valid    (l2_valid),
        .l2_error    (l2_error),
        .l2_ppn      (l2_ppn),
        .l2_perm     (l2_perm),
        .refill      (refill.arbiter)
    );

endmodule

`default_nettype wire

/* testbench/dtlb_props.sv */
`timescale 1ns/1ps
`default_nettype none

module dtlb_props (
    input logic clk,
    input logic arst_n,
    input logic l2_req,
    input logic ld_wb,
    input logic st_wb,
    input logic we,
    input logic inval_all
);

    int unsigned failures = 0;

    // Only one walk is in flight, so every request is a single pulse.
    property req_single_pulse;
        @(posedge clk) disable iff (!arst_n) l2_req |=> !l2_req;
    endproperty

    property wb_single_owner;
        @(posedge clk) disable iff (!arst_n) !(ld_wb && st_wb);
    endproperty

    // A flush drops the walk, so no refill may land in the same cycle.
    property no_refill_on_flush;
        @(posedge clk) disable iff (!arst_n) !(we && inval_all);
    endproperty

    assert property (req_single_pulse) else begin
        $error("l2_req was high for two cycles in a row");
        failures++;
    end

    assert property (wb_single_owner) else begin
        $error("ld_wb and st_wb were high together");
        failures++;
    end

    assert property (no_refill_on_flush) else begin
        $error("refill write and invalidate were high together");
        failures++;
    end

endmodule

bind dtlb_miss_arbiter dtlb_props i_props (
    .clk       (clk),
    .arst_n    (arst_n),
    .l2_req    (l2_req),
    .ld_wb     (ld_wb),
    .st_wb     (st_wb),
    .we        (refill.we),
    .inval_all (refill.inval_all)
);

`default_nettype wire

/* testbench/dtlb_tb.sv */
`timescale 1ns/1ps
`include "dtlb_cfg.svh"
`default_nettype none

module dtlb_tb;
    import dtlb_pkg::*;

    localparam int NSTEPS     = 35;
    localparam int RST_CYCLES = 8;

    typedef enum logic [1:0] {
        L2_NONE,
        L2_OK,
        L2_ERR
    } l2_action_e;

    // Expected bits, msb first: ld hit, miss, exception, st hit, miss, exception,
    // ld cancel, st cancel, ld wb, st wb, wb_error, l2_req.
    typedef struct packed {
        logic                  ld_req;
        logic [`VPN_WIDTH-1:0] ld_vpn;
        logic                  st_req;
        logic [`VPN_WIDTH-1:0] st_vpn;
        l2_action_e            act;
        tlb_perm_t             perm;
        logic                  flush;
        logic [11:0]           exp;
        tlb_source_e           src;
    } step_t;

    localparam tlb_perm_t RW = '{readable: 1'b1, writable: 1'b1};
    localparam tlb_perm_t RO = '{readable: 1'b1, writable: 1'b0};

    localparam logic [`VPN_WIDTH-1:0] VPN_A = 20'h00010;
    localparam logic [`VPN_WIDTH-1:0] VPN_B = 20'h00020;
    localparam logic [`VPN_WIDTH-1:0] VPN_C = 20'h00030;
    localparam logic [`VPN_WIDTH-1:0] VPN_D = 20'h00040;
    localparam logic [`VPN_WIDTH-1:0] VPN_E = 20'h00050;
    localparam logic [`VPN_WIDTH-1:0] VPN_1 = 20'h01000;
    localparam logic [`VPN_WIDTH-1:0] VPN_2 = 20'h02000;
    localparam logic [`VPN_WIDTH-1:0] VPN_3 = 20'h03000;
    localparam logic [`VPN_WIDTH-1:0] VPN_4 = 20'h04000;

    logic                          clk;
    logic                          arst_n;
    logic                          flush;
    logic                          ld_req;
    logic [`VADDR_WIDTH-1:0]       ld_vaddr;
    logic                          ld_hit;
    logic                          ld_miss;
    logic                          ld_exception;
    logic [`PADDR_WIDTH-1:0]       ld_paddr;
    logic                          ld_cancel;
    logic                          ld_wb;
    logic                          st_req;
    logic [`VADDR_WIDTH-1:0]       st_vaddr;
    logic                          st_hit;
    logic                          st_miss;
    logic                          st_exception;
    logic [`PADDR_WIDTH-1:0]       st_paddr;
    logic                          st_cancel;
    logic                          st_wb;
    logic                          wb_error;
    logic                          l2_req;
    tlb_source_e                   l2_source;
    logic [`VADDR_WIDTH-1:0]       l2_vaddr;
    logic                          l2_valid;
    logic [`PPN_WIDTH-1:0]         l2_ppn;
    tlb_perm_t                     l2_perm;
    logic                          l2_error;

    step_t                         steps [NSTEPS];
    logic [15:0]                   lfsr;
    logic [`PAGE_OFFSET_WIDTH-1:0] ld_off;
    logic [`PAGE_OFFSET_WIDTH-1:0] st_off;
    logic [`VPN_WIDTH-1:0]         walk_vpn;
    int                            cur_step;
    int                            bit_errs;
    int                            addr_errs;
    int                            src_errs;
    int                            total_errs;
    string bit_names [12] = '{"ld_hit", "ld_miss", "ld_exception", "st_hit", "st_miss",
        "st_exception", "ld_cancel", "st_cancel", "ld_wb", "st_wb", "wb_error", "l2_req"};

    dtlb_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Models and checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Page table of the L2 model.
    function automatic logic [`PPN_WIDTH-1:0] ppn_of(input logic [`VPN_WIDTH-1:0] vpn);
        return vpn ^ 20'hA5C30;
    endfunction

    function automatic logic [`PAGE_OFFSET_WIDTH-1:0] next_offset();
        logic [`PAGE_OFFSET_WIDTH-1:0] bits;
        for (int i = 0; i < `PAGE_OFFSET_WIDTH; i++) begin
            bits[i] = lfsr[0];
            lfsr    = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return bits;
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED step %0d %s: got 0x%h expected 0x%h", cur_step, name, got, exp);
            bit_errs++;
        end
    endtask

    task automatic check_addr(input string name, input logic [`PADDR_WIDTH-1:0] got,
                              input logic [`PADDR_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("FAILED step %0d %s: got 0x%h expected 0x%h", cur_step, name, got, exp);
            addr_errs++;
        end
    endtask

    task automatic check_source(input string name, input tlb_source_e got,
                                input tlb_source_e exp);
        if (got !== exp) begin
            $display("FAILED step %0d %s: got 0x%h expected 0x%h", cur_step, name, got, exp);
            src_errs++;
        end
    endtask

    task automatic drive_step(input step_t s);
        ld_off   = next_offset();
        st_off   = next_offset();
        ld_req   = s.ld_req;
        ld_vaddr = {s.ld_vpn, ld_off};
        st_req   = s.st_req;
        st_vaddr = {s.st_vpn, st_off};
        l2_valid = (s.act != L2_NONE);
        l2_error = (s.act == L2_ERR);
        l2_ppn   = ppn_of(walk_vpn);
        l2_perm  = s.perm;
        flush    = s.flush;
    endtask

    task automatic verify_step(input int k);
        step_t                 s;
        logic [11:0]           got;
        logic [`VPN_WIDTH-1:0] req_vpn;
        s        = steps[k];
        cur_step = k;
        got = {ld_hit, ld_miss, ld_exception, st_hit, st_miss, st_exception,
               ld_cancel, st_cancel, ld_wb, st_wb, wb_error, l2_req};
        for (int b = 0; b < 12; b++) begin
            check_bit(bit_names[b], got[11-b], s.exp[11-b]);
        end
        if (s.exp[11]) begin
            check_addr("ld_paddr", ld_paddr, {ppn_of(s.ld_vpn), ld_off});
        end
        if (s.exp[8]) begin
            check_addr("st_paddr", st_paddr, {ppn_of(s.st_vpn), st_off});
        end
        // The walk was requested by the miss of the step before.
        if (s.exp[0]) begin
            req_vpn = (s.src == SRC_STORE) ? steps[k-1].st_vpn : steps[k-1].ld_vpn;
            check_source("l2_source", l2_source, s.src);
            check_addr("l2_vaddr", l2_vaddr, {req_vpn, {`PAGE_OFFSET_WIDTH{1'b0}}});
        end
        if (l2_req) begin
            walk_vpn = l2_vaddr[`VADDR_WIDTH-1:`PAGE_OFFSET_WIDTH];
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Step table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic load_table();
        // Load miss, walk with one idle cycle of latency, then a hit.
        steps[0]  = '{1'b1, VPN_A, 1'b0, VPN_A, L2_NONE, RW, 1'b0, 12'b010_000_00_00_0_0, SRC_LOAD};
        steps[1]  = '{1'b0, VPN_A, 1'b0, VPN_A, L2_NONE, RW, 1'b0, 12'b000_000_00_00_0_1, SRC_LOAD};
        steps[2]  = '{1'b0, VPN_A, 1'b0, VPN_A, L2_NONE, RW, 1'b0, 12'b000_000_00_00_0_0, SRC_LOAD};
        steps[3]  = '{1'b0, VPN_A, 1'b0, VPN_A, L2_OK,   RW, 1'b0, 12'b000_000_00_10_0_0, SRC_LOAD};
        steps[4]  = '{1'b1, VPN_A, 1'b0, VPN_A, L2_NONE, RW, 1'b0, 12'b100_000_00_00_0_0, SRC_LOAD};
        // Read-only page: the store faults, the load hits.
        steps[5]  = '{1'b1, VPN_B, 1'b0, VPN_A, L2_NONE, RW, 1'b0, 12'b010_000_00_00_0_0, SRC_LOAD};
        steps[6]  = '{1'b0, VPN_B, 1'b0, VPN_A, L2_NONE, RW, 1'b0, 12'b000_000_00_00_0_1, SRC_LOAD};
        steps[7]  = '{1'b0, VPN_B, 1'b0, VPN_A, L2_OK,   RO, 1'b0, 12'b000_000_00_10_0_0, SRC_LOAD};
        steps[8]  = '{1'b1, VPN_B, 1'b1, VPN_B, L2_NONE, RW, 1'b0, 12'b100_001_00_00_0_0, SRC_LOAD};
        // Both ports miss, the store wins and a third miss lands in the walk.
        steps[9]  = '{1'b1, VPN_C, 1'b1, VPN_D, L2_NONE, RW, 1'b0, 12'b010_010_00_00_0_0, SRC_LOAD};
        steps[10] = '{1'b1, VPN_E, 1'b0, VPN_D, L2_NONE, RW, 1'b0, 12'b010_000_10_00_0_1, SRC_STORE};
        steps[11] = '{1'b0, VPN_E, 1'b0, VPN_D, L2_OK,   RW, 1'b0, 12'b000_000_10_01_0_0, SRC_LOAD};
        // Error response writes nothing.
        steps[12] = '{1'b1, VPN_C, 1'b1, VPN_D, L2_NONE, RW, 1'b0, 12'b010_100_00_00_0_0, SRC_LOAD};
        steps[13] = '{1'b0, VPN_C, 1'b0, VPN_D, L2_NONE, RW, 1'b0, 12'b000_000_00_00_0_1, SRC_LOAD};
        steps[14] = '{1'b0, VPN_C, 1'b0, VPN_D, L2_ERR,  RW, 1'b0, 12'b000_000_00_10_1_0, SRC_LOAD};
        steps[15] = '{1'b1, VPN_C, 1'b0, VPN_D, L2_NONE, RW, 1'b0, 12'b010_000_00_00_0_0, SRC_LOAD};
        steps[16] = '{1'b0, VPN_C, 1'b0, VPN_D, L2_NONE, RW, 1'b0, 12'b000_000_00_00_0_1, SRC_LOAD};
        // Flush during the walk; the late response is dropped.
        steps[17] = '{1'b0, VPN_C, 1'b0, VPN_D, L2_NONE, RW, 1'b1, 12'b000_000_00_00_0_0, SRC_LOAD};
        steps[18] = '{1'b0, VPN_C, 1'b0, VPN_D, L2_OK,   RW, 1'b0, 12'b000_000_00_00_0_0, SRC_LOAD};
        steps[19] = '{1'b1, VPN_A, 1'b1, VPN_D, L2_NONE, RW, 1'b0, 12'b010_010_00_00_0_0, SRC_LOAD};
        steps[20] = '{1'b0, VPN_A, 1'b0, VPN_D, L2_NONE, RW, 1'b0, 12'b000_000_10_00_0_1, SRC_STORE};
        steps[21] = '{1'b0, VPN_A, 1'b0, VPN_D, L2_OK,   RW, 1'b0, 12'b000_000_00_01_0_0, SRC_LOAD};
        // Four more pages wrap the victim pointer onto the first one.
        steps[22] = '{1'b1, VPN_1, 1'b0, VPN_D, L2_NONE, RW, 1'b0, 12'b010_000_00_00_0_0, SRC_LOAD};
        steps[23] = '{1'b0, VPN_1, 1'b0, VPN_D, L2_NONE, RW, 1'b0, 12'b000_000_00_00_0_1, SRC_LOAD};
        steps[24] = '{1'b1, VPN_2, 1'b0, VPN_D, L2_OK,   RW, 1'b0, 12'b010_000_00_10_0_0, SRC_LOAD};
        steps[25] = '{1'b0, VPN_2, 1'b0, VPN_D, L2_NONE, RW, 1'b0, 12'b000_000_00_00_0_1, SRC_LOAD};
        steps[26] = '{1'b1, VPN_3, 1'b0, VPN_D, L2_OK,   RW, 1'b0, 12'b010_000_00_10_0_0, SRC_LOAD};
        steps[27] = '{1'b0, VPN_3, 1'b0, VPN_D, L2_NONE, RW, 1'b0, 12'b000_000_00_00_0_1, SRC_LOAD};
        steps[28] = '{1'b1, VPN_4, 1'b0, VPN_D, L2_OK,   RW, 1'b0, 12'b010_000_00_10_0_0, SRC_LOAD};
        steps[29] = '{1'b0, VPN_4, 1'b0, VPN_D, L2_NONE, RW, 1'b0, 12'b000_000_00_00_0_1, SRC_LOAD};
        steps[30] = '{1'b0, VPN_4, 1'b0, VPN_D, L2_OK,   RW, 1'b0, 12'b000_000_00_10_0_0, SRC_LOAD};
        steps[31] = '{1'b1, VPN_1, 1'b1, VPN_D, L2_NONE, RW, 1'b0, 12'b100_010_00_00_0_0, SRC_LOAD};
        steps[32] = '{1'b1, VPN_2, 1'b0, VPN_D, L2_NONE, RW, 1'b0, 12'b100_000_00_00_0_1, SRC_STORE};
        steps[33] = '{1'b1, VPN_3, 1'b0, VPN_D, L2_NONE, RW, 1'b0, 12'b100_000_00_00_0_0, SRC_LOAD};
        steps[34] = '{1'b1, VPN_4, 1'b0, VPN_D, L2_NONE, RW, 1'b0, 12'b100_000_00_00_0_0, SRC_LOAD};
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sequence and watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        load_table();
        lfsr      = 16'd68;
        walk_vpn  = '0;
        bit_errs  = 0;
        addr_errs = 0;
        src_errs  = 0;
        arst_n    = 1'b0;
        flush     = 1'b0;
        ld_req    = 1'b0;
        ld_vaddr  = '0;
        st_req    = 1'b0;
        st_vaddr  = '0;
        l2_valid  = 1'b0;
        l2_ppn    = '0;
        l2_perm   = '0;
        l2_error  = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        // Each step is one cycle, checked at the next falling edge.
        for (int k = 0; k < NSTEPS; k++) begin
            drive_step(steps[k]);
            @(negedge clk);
            verify_step(k);
        end
        total_errs = bit_errs + addr_errs + src_errs + i_dut.i_arbiter.i_props.failures;
        $display("Errors: %0d bit, %0d address, %0d source, %0d assertion",
                 bit_errs, addr_errs, src_errs, i_dut.i_arbiter.i_props.failures);
        if (total_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        repeat (RST_CYCLES + NSTEPS * 20) @(posedge clk);
        $display("Timeout: the step table did not complete in %0d cycles", NSTEPS * 20);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* dtlb_top.f */
+incdir+hdl
hdl/dtlb_pkg.sv
hdl/tlb_refill_if.sv
hdl/dtlb_array.sv
hdl/dtlb_miss_arbiter.sv
hdl/dtlb_top.sv
testbench/dtlb_props.sv
testbench/dtlb_tb.sv

/* Bender.yml */
package:
  name: dtlb

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/dtlb_pkg.sv
      - hdl/tlb_refill_if.sv
      - hdl/dtlb_array.sv
      - hdl/dtlb_miss_arbiter.sv
      - hdl/dtlb_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/dtlb_props.sv
      - testbench/dtlb_tb.sv
